//--- logic/dcache_pkg.sv
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache geometry
  //////////////////////////////////////////////////////////////////////
  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int LINE_WORDS = 16;

  localparam int SET_BITS  = 4;
  localparam int WORD_BITS = 4;
  localparam int TAG_BITS  = 22;   // 32 - SET_BITS - WORD_BITS - 2

  //////////////////////////////////////////////////////////////////////
  // Data and address fields
  //////////////////////////////////////////////////////////////////////
  typedef logic [31:0]            word_t;
  typedef logic [31:0]            addr_t;
  typedef logic [TAG_BITS-1:0]    tag_t;    // addr[31:10]
  typedef logic [SET_BITS-1:0]    set_t;    // addr[9:6]
  typedef logic [WORD_BITS-1:0]   offset_t; // addr[5:2]
  typedef logic [1:0]             way_t;
  typedef logic [3:0]             be_t;     // Bit 3 is the top byte
  typedef logic [1:0]             age_t;

  // Request FSM
  typedef enum logic [1:0]
  {
    IDLE,
    WRITEBACK,
    REFILL,
    RESPOND
  } ctrl_state_e;

endpackage

//--- logic/burst_if.sv
`timescale 1ns/1ps

interface burst_if;

  logic                start;     // One-cycle command
  logic                is_wb;
  dcache_pkg::way_t    way;       // Target line
  dcache_pkg::set_t    set;
  logic                beat;      // One strobe per word
  dcache_pkg::offset_t beat_idx;
  dcache_pkg::word_t   fill_data;
  dcache_pkg::word_t   wb_data;
  logic                done;

  modport ctrl (output start, is_wb, way, set, input done);

  modport engine (input start, is_wb, set, wb_data,
                  output beat, beat_idx, fill_data, done);

  modport store (input way, set, is_wb, beat, beat_idx, fill_data,
                 output wb_data);

endinterface

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
(
  input  logic                clk,
  input  logic                rst,
  input  dcache_pkg::addr_t   addr,
  input  dcache_pkg::word_t   din,
  input  dcache_pkg::be_t     wbyte,
  input  logic                req,
  input  logic                wreq,
  output dcache_pkg::word_t   ins,
  output logic                ok,
  output logic                busy,
  input  logic                hit,
  input  dcache_pkg::way_t    hit_way,
  input  dcache_pkg::way_t    victim_way,
  input  logic                victim_dirty,
  input  dcache_pkg::word_t   rd_word,
  output dcache_pkg::way_t    access_way,
  output logic                access,
  output logic                cpu_we,
  output dcache_pkg::be_t     cpu_be,
  output dcache_pkg::word_t   cpu_data,
  output dcache_pkg::tag_t    cpu_tag,
  output dcache_pkg::set_t    cpu_set,
  output dcache_pkg::offset_t cpu_off,
  output logic                line_fill,
  output logic                mark_dirty,
  burst_if.ctrl               burst
);

  dcache_pkg::ctrl_state_e state;
  dcache_pkg::ctrl_state_e state_nxt;

  // Held miss request
  dcache_pkg::addr_t addr_q;
  dcache_pkg::word_t din_q;
  dcache_pkg::be_t   be_q;
  logic              wreq_q;
  dcache_pkg::way_t  way_q;

  dcache_pkg::addr_t cur_addr;
  logic              cur_wr;
  logic              idle;
  logic              in_wb;
  logic              respond;
  logic              hit_req;
  logic              miss_req;

  assign idle     = (state == dcache_pkg::IDLE);
  assign in_wb    = (state == dcache_pkg::WRITEBACK);
  assign respond  = (state == dcache_pkg::RESPOND);
  assign hit_req  = idle && req && hit;
  assign miss_req = idle && req && !hit;
  assign busy     = !idle;

  // Live request while idle and the held one otherwise
  assign cur_addr = idle ? addr : addr_q;
  assign cur_wr   = idle ? wreq : wreq_q;
  assign cpu_tag  = cur_addr[31 -: dcache_pkg::TAG_BITS];
  assign cpu_set  = cur_addr[2 + dcache_pkg::WORD_BITS +: dcache_pkg::SET_BITS];
  assign cpu_off  = cur_addr[2 +: dcache_pkg::WORD_BITS];

  assign access_way = idle ? (hit ? hit_way : victim_way) : way_q;
  assign access     = hit_req || respond;    // Replay in RESPOND counts as a hit
  assign cpu_we     = access && cur_wr;
  assign cpu_be     = idle ? wbyte : be_q;
  assign cpu_data   = idle ? din : din_q;
  assign mark_dirty = cpu_we;
  assign line_fill  = (state == dcache_pkg::REFILL) && burst.done;

  assign burst.way   = access_way;
  assign burst.set   = cpu_set;
  assign burst.start = miss_req || (in_wb && burst.done);
  // Refill always follows the write-back
  assign burst.is_wb = idle ? victim_dirty : (in_wb && !burst.done);

  always_comb
  begin
    state_nxt = state;
    case (state)
      dcache_pkg::IDLE:
        if (miss_req)
          state_nxt = victim_dirty ? dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
      dcache_pkg::WRITEBACK:
        if (burst.done)
          state_nxt = dcache_pkg::REFILL;
      dcache_pkg::REFILL:
        if (burst.done)
          state_nxt = dcache_pkg::RESPOND;
      default:
        state_nxt = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= dcache_pkg::IDLE;
      ok    <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      ok    <= access;
    end
  end

  always_ff @(posedge clk)
  begin
    if (miss_req)
    begin
      addr_q <= addr;
      din_q  <= din;
      be_q   <= wbyte;
      wreq_q <= wreq;
      way_q  <= victim_way;
    end
    if (access)
      ins <= cur_wr ? cpu_data : rd_word;   // Written word on a write
  end

endmodule

//--- logic/tag_store.sv
`timescale 1ns/1ps

module tag_store
(
  input  logic              clk,
  input  logic              rst,
  input  dcache_pkg::tag_t  lookup_tag,
  input  dcache_pkg::set_t  lookup_set,
  input  logic              line_fill,
  input  logic              mark_dirty,
  input  dcache_pkg::way_t  access_way,
  input  dcache_pkg::way_t  lru_oldest,
  output logic              hit,
  output dcache_pkg::way_t  hit_way,
  output dcache_pkg::way_t  victim_way,
  output logic              victim_dirty,
  output dcache_pkg::tag_t  victim_tag
);

  dcache_pkg::tag_t tags [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] valid;
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] dirty;
  logic [dcache_pkg::WAYS-1:0] hit_vec;

  // All ways compared at once
  always_comb
  begin
    for (int w = 0; w < dcache_pkg::WAYS; w++)
      hit_vec[w] = valid[w][lookup_set] && (tags[w][lookup_set] == lookup_tag);
  end

  assign hit = |hit_vec;

  always_comb
  begin
    hit_way    = '0;
    victim_way = lru_oldest;
    for (int w = dcache_pkg::WAYS - 1; w >= 0; w--)
    begin
      if (hit_vec[w])
        hit_way = dcache_pkg::way_t'(w);
      if (!valid[w][lookup_set])
        victim_way = dcache_pkg::way_t'(w);   // Lowest invalid way wins
    end
  end

  assign victim_dirty = valid[victim_way][lookup_set] && dirty[victim_way][lookup_set];
  assign victim_tag   = tags[victim_way][lookup_set];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else if (line_fill)
    begin
      valid[access_way][lookup_set] <= 1'b1;
      dirty[access_way][lookup_set] <= 1'b0;
    end
    else if (mark_dirty)
      dirty[access_way][lookup_set] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (line_fill)
      tags[access_way][lookup_set] <= lookup_tag;
  end

endmodule

//--- logic/lru_policy.sv
`timescale 1ns/1ps

module lru_policy
(
  input  logic             clk,
  input  logic             rst,
  input  dcache_pkg::set_t set,
  input  logic             access,
  input  dcache_pkg::way_t access_way,
  output dcache_pkg::way_t oldest
);

  dcache_pkg::age_t [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] age_q;
  dcache_pkg::age_t [dcache_pkg::WAYS-1:0] age_nxt;
  dcache_pkg::age_t hit_age;
  dcache_pkg::age_t best;

  assign hit_age = age_q[set][access_way];

  // Younger ways age by one and saturate at 3
  always_comb
  begin
    for (int w = 0; w < dcache_pkg::WAYS; w++)
    begin
      if (dcache_pkg::way_t'(w) == access_way)
        age_nxt[w] = '0;
      else if (age_q[set][w] <= hit_age && age_q[set][w] != '1)
        age_nxt[w] = age_q[set][w] + 1'b1;
      else
        age_nxt[w] = age_q[set][w];
    end
  end

  always_comb
  begin
    oldest = '0;
    best   = age_q[set][0];
    for (int w = 1; w < dcache_pkg::WAYS; w++)
    begin
      if (age_q[set][w] > best)   // Strict so that ties keep the lower way
      begin
        best   = age_q[set][w];
        oldest = dcache_pkg::way_t'(w);
      end
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      age_q <= '0;
    else if (access)
      age_q[set] <= age_nxt;
  end

endmodule

//--- logic/data_store.sv
`timescale 1ns/1ps

module data_store
(
  input  logic                clk,
  input  dcache_pkg::way_t    cpu_way,
  input  dcache_pkg::set_t    cpu_set,
  input  dcache_pkg::offset_t cpu_off,
  input  logic                cpu_we,
  input  dcache_pkg::be_t     cpu_be,
  input  dcache_pkg::word_t   cpu_data,
  output dcache_pkg::word_t   rd_word,
  burst_if.store              burst
);

  dcache_pkg::word_t mem [dcache_pkg::WAYS][dcache_pkg::SETS][dcache_pkg::LINE_WORDS];

  assign rd_word       = mem[cpu_way][cpu_set][cpu_off];
  assign burst.wb_data = mem[burst.way][burst.set][burst.beat_idx];   // Victim word out

  //////////////////////////////////////////////////////////////////////
  // Refill beats and byte-masked CPU writes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (burst.beat && !burst.is_wb)
      mem[burst.way][burst.set][burst.beat_idx] <= burst.fill_data;
    if (cpu_we)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (cpu_be[b])
          mem[cpu_way][cpu_set][cpu_off][8*b +: 8] <= cpu_data[8*b +: 8];
      end
    end
  end

endmodule

//--- logic/burst_engine.sv
`timescale 1ns/1ps

module burst_engine
(
  input  logic              clk,
  input  logic              rst,
  input  dcache_pkg::tag_t  line_tag,
  input  dcache_pkg::tag_t  victim_tag,
  output logic              sen,
  output logic              wen,
  output dcache_pkg::addr_t raddr,
  output dcache_pkg::addr_t waddr,
  input  dcache_pkg::word_t sdata,
  input  logic              rdata_ok,
  input  logic              wdata_ok,
  output dcache_pkg::word_t wdata,
  burst_if.engine           burst
);

  logic                active;
  logic                wb_q;
  logic                done_q;
  dcache_pkg::offset_t cnt;
  logic                strobe;
  logic                last;

  assign sen    = active && !wb_q;
  assign wen    = active && wb_q;
  assign strobe = wb_q ? wdata_ok : rdata_ok;
  assign last   = burst.beat && (cnt == '1);   // 16th word

  assign burst.beat      = active && strobe;
  assign burst.beat_idx  = cnt;
  assign burst.fill_data = sdata;
  assign burst.done      = done_q;
  assign wdata           = burst.wb_data;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active <= 1'b0;
      wb_q   <= 1'b0;
      done_q <= 1'b0;
      cnt    <= '0;
    end
    else
    begin
      done_q <= last;
      if (burst.start)
      begin
        active <= 1'b1;
        wb_q   <= burst.is_wb;
        cnt    <= '0;
      end
      else if (burst.beat)
      begin
        cnt <= cnt + 1'b1;
        if (last)
          active <= 1'b0;
      end
    end
  end

  // Line base held for the whole burst
  always_ff @(posedge clk)
  begin
    if (burst.start)
    begin
      if (burst.is_wb)
        waddr <= {victim_tag, burst.set, {(dcache_pkg::WORD_BITS + 2){1'b0}}};
      else
        raddr <= {line_tag, burst.set, {(dcache_pkg::WORD_BITS + 2){1'b0}}};
    end
  end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
(
  input  logic               clk,
  input  logic               rst,
  // CPU side
  input  dcache_pkg::addr_t  addr,
  input  dcache_pkg::word_t  din,
  input  dcache_pkg::be_t    wbyte,
  input  logic               req,
  input  logic               wreq,
  output dcache_pkg::word_t  ins,
  output logic               ok,
  output logic               busy,
  // Memory side
  output logic               sen,
  output dcache_pkg::addr_t  raddr,
  input  dcache_pkg::word_t  sdata,
  input  logic               rdata_ok,
  output logic               wen,
  output dcache_pkg::addr_t  waddr,
  output dcache_pkg::word_t  wdata,
  input  logic               wdata_ok
);

  logic                hit;
  dcache_pkg::way_t    hit_way;
  dcache_pkg::way_t    victim_way;
  logic                victim_dirty;
  dcache_pkg::tag_t    victim_tag;
  dcache_pkg::word_t   rd_word;
  dcache_pkg::way_t    access_way;
  logic                access;
  logic                cpu_we;
  dcache_pkg::be_t     cpu_be;
  dcache_pkg::word_t   cpu_data;
  dcache_pkg::tag_t    cpu_tag;
  dcache_pkg::set_t    cpu_set;
  dcache_pkg::offset_t cpu_off;
  logic                line_fill;
  logic                mark_dirty;
  dcache_pkg::way_t    lru_oldest;

  burst_if bus ();

  dcache_ctrl u_ctrl
  (
    .clk          (clk),
    .rst          (rst),
    .addr         (addr),
    .din          (din),
    .wbyte        (wbyte),
    .req          (req),
    .wreq         (wreq),
    .ins          (ins),
    .ok           (ok),
    .busy         (busy),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .rd_word      (rd_word),
    .access_way   (access_way),
    .access       (access),
    .cpu_we       (cpu_we),
    .cpu_be       (cpu_be),
    .cpu_data     (cpu_data),
    .cpu_tag      (cpu_tag),
    .cpu_set      (cpu_set),
    .cpu_off      (cpu_off),
    .line_fill    (line_fill),
    .mark_dirty   (mark_dirty),
    .burst        (bus.ctrl)
  );

  tag_store u_tags
  (
    .clk          (clk),
    .rst          (rst),
    .lookup_tag   (cpu_tag),
    .lookup_set   (cpu_set),
    .line_fill    (line_fill),
    .mark_dirty   (mark_dirty),
    .access_way   (access_way),
    .lru_oldest   (lru_oldest),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  lru_policy u_lru
  (
    .clk        (clk),
    .rst        (rst),
    .set        (cpu_set),
    .access     (access),
    .access_way (access_way),
    .oldest     (lru_oldest)
  );

  data_store u_data
  (
    .clk      (clk),
    .cpu_way  (access_way),
    .cpu_set  (cpu_set),
    .cpu_off  (cpu_off),
    .cpu_we   (cpu_we),
    .cpu_be   (cpu_be),
    .cpu_data (cpu_data),
    .rd_word  (rd_word),
    .burst    (bus.store)
  );

  burst_engine u_burst
  (
    .clk        (clk),
    .rst        (rst),
    .line_tag   (cpu_tag),
    .victim_tag (victim_tag),
    .sen        (sen),
    .wen        (wen),
    .raddr      (raddr),
    .waddr      (waddr),
    .sdata      (sdata),
    .rdata_ok   (rdata_ok),
    .wdata_ok   (wdata_ok),
    .wdata      (wdata),
    .burst      (bus.engine)
  );

endmodule

//--- tb/mem_model.sv
`timescale 1ns/1ps

module mem_model
(
  input  logic              clk,
  input  logic              sen,
  input  dcache_pkg::addr_t raddr,
  output dcache_pkg::word_t sdata,
  output logic              rdata_ok,
  input  logic              wen,
  input  dcache_pkg::addr_t waddr,
  input  dcache_pkg::word_t wdata,
  output logic              wdata_ok,
  output int                wb_beats
);

  localparam int MEM_WORDS = 4096;   // 16 KB backing store

  dcache_pkg::word_t mem [MEM_WORDS];
  integer            seed;
  int                gap;
  int                idx;
  bit                in_burst;

  //////////////////////////////////////////////////////////////////////
  // Burst responder with one strobe per word after 0 to 3 idle cycles
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    seed     = 97954;
    sdata    = '0;
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    wb_beats = 0;
    gap      = 0;
    idx      = 0;
    in_burst = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = (dcache_pkg::word_t'(i) << 2) ^ 32'h5a5a0000;

    forever
    begin
      @(posedge clk);
      #1;
      rdata_ok = 1'b0;
      wdata_ok = 1'b0;
      if (!(sen || wen))
        in_burst = 1'b0;
      else
      begin
        if (!in_burst)   // New burst
        begin
          in_burst = 1'b1;
          idx      = 0;
          gap      = $unsigned($random(seed)) % 4;
          if (wen)
            wb_beats = 0;
        end
        if (gap > 0)
          gap--;
        else
        begin
          if (sen)
          begin
            sdata    = mem[{raddr[13:6], idx[3:0]}];
            rdata_ok = 1'b1;
          end
          else
          begin
            mem[{waddr[13:6], idx[3:0]}] = wdata;   // Victim word kept
            wdata_ok = 1'b1;
            wb_beats++;
          end
          idx++;
          gap = $unsigned($random(seed)) % 4;
        end
      end
    end
  end

endmodule

//--- tb/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

  localparam int TIMEOUT_CYCLES = 500;

  logic              clk;
  logic              rst;
  dcache_pkg::addr_t addr;
  dcache_pkg::word_t din;
  dcache_pkg::be_t   wbyte;
  logic              req;
  logic              wreq;
  dcache_pkg::word_t ins;
  logic              ok;
  logic              busy;
  logic              sen;
  dcache_pkg::addr_t raddr;
  dcache_pkg::word_t sdata;
  logic              rdata_ok;
  logic              wen;
  dcache_pkg::addr_t waddr;
  dcache_pkg::word_t wdata;
  logic              wdata_ok;
  int                wb_beats;

  // Stimulus file fields
  int                  stim_fd;
  int                  fields;
  int                  ops_run;
  logic [8*128-1:0]    line_buf;
  int                  stim_op;
  dcache_pkg::addr_t   stim_addr;
  dcache_pkg::word_t   stim_data;
  dcache_pkg::be_t     stim_be;
  dcache_pkg::word_t   stim_word;
  bit                  stim_miss;

  dcache_top u_dut
  (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .din      (din),
    .wbyte    (wbyte),
    .req      (req),
    .wreq     (wreq),
    .ins      (ins),
    .ok       (ok),
    .busy     (busy),
    .sen      (sen),
    .raddr    (raddr),
    .sdata    (sdata),
    .rdata_ok (rdata_ok),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata),
    .wdata_ok (wdata_ok)
  );

  mem_model u_mem
  (
    .clk      (clk),
    .sen      (sen),
    .raddr    (raddr),
    .sdata    (sdata),
    .rdata_ok (rdata_ok),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata),
    .wdata_ok (wdata_ok),
    .wb_beats (wb_beats)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Result checks
  //////////////////////////////////////////////////////////////////////
  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input dcache_pkg::word_t expected,
                            input dcache_pkg::word_t actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input dcache_pkg::addr_t expected,
                            input dcache_pkg::addr_t actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input bit expected, input logic actual);
    if (actual !== expected)
    begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_on_error();
    end
  endtask

  // One CPU request and the wait for ok
  task automatic run_request(input int op, input dcache_pkg::addr_t a,
                             input dcache_pkg::word_t d, input dcache_pkg::be_t be,
                             input dcache_pkg::word_t exp_word, input bit exp_miss);
    bit missed;
    int cycles;
    addr  = a;
    din   = d;
    wbyte = be;
    wreq  = (op == 1);
    req   = 1'b1;
    @(posedge clk);
    #1;
    req    = 1'b0;
    wreq   = 1'b0;
    missed = busy;   // Busy rises right after a missing req
    cycles = 0;
    check_flag("busy", exp_miss, missed);
    if (!missed)
      check_flag("ok", 1'b1, ok);
    while (!ok)
    begin
      if (cycles >= TIMEOUT_CYCLES)
      begin
        $display("Timed out waiting for ok after a request to address %h", a);
        stop_on_error();
      end
      check_flag("busy", 1'b1, busy);
      @(posedge clk);
      #1;
      cycles++;
    end
    check_flag("busy", 1'b0, busy);
    check_word("ins", exp_word, ins);
    if (missed)
      check_addr("raddr", {a[31:6], 6'b0}, raddr);
  endtask

  // Last write-back burst went to this line base
  task automatic expect_writeback(input dcache_pkg::addr_t base);
    check_addr("waddr", base, waddr);
    if (wb_beats != 16)
    begin
      $display("Write-back burst carried %0d words instead of 16", wb_beats);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    clk     = 1'b0;
    rst     = 1'b1;
    addr    = '0;
    din     = '0;
    wbyte   = '0;
    req     = 1'b0;
    wreq    = 1'b0;
    ops_run = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    check_flag("ok", 1'b0, ok);
    check_flag("busy", 1'b0, busy);
    check_flag("sen", 1'b0, sen);
    check_flag("wen", 1'b0, wen);

    stim_fd = $fopen("tb/dcache_stim.txt", "r");
    if (stim_fd == 0)
    begin
      $display("Could not open the stimulus file");
      stop_on_error();
    end
    while (!$feof(stim_fd))
    begin
      line_buf = '0;
      if ($fgets(line_buf, stim_fd) != 0)
      begin
        // Comment and blank lines yield no fields
        fields = $sscanf(line_buf, "%h %h %h %h %h %h", stim_op, stim_addr, stim_data,
                         stim_be, stim_word, stim_miss);
        if (fields == 6)
        begin
          if (stim_op == 2)
            expect_writeback(stim_addr);
          else
            run_request(stim_op, stim_addr, stim_data, stim_be, stim_word, stim_miss);
          ops_run++;
        end
      end
    end
    $fclose(stim_fd);

    if (ops_run > 0)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      $display("No operations found in the stimulus file");
      stop_on_error();
    end
  end

endmodule

//--- dcache_top.f
logic/dcache_pkg.sv
logic/burst_if.sv
logic/dcache_ctrl.sv
logic/tag_store.sv
logic/lru_policy.sv
logic/data_store.sv
logic/burst_engine.sv
logic/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

//--- tb/dcache_stim.txt
# op addr data be exp_word exp_miss, all hex; op 0 read, 1 write, 2 write-back check
# op 2 compares the last write-back line base with the addr column
0 00000044 00000000 0 5a5a0044 1
0 00000048 00000000 0 5a5a0048 0
1 0000004c 1234abcd 3 1234abcd 0
0 0000004c 00000000 0 5a5aabcd 0
0 00000440 00000000 0 5a5a0440 1
0 00000840 00000000 0 5a5a0840 1
0 00000c40 00000000 0 5a5a0c40 1
0 00001040 00000000 0 5a5a1040 1
2 00000040 00000000 0 00000000 0
0 00000444 00000000 0 5a5a0444 0
0 0000004c 00000000 0 5a5aabcd 1
0 00000c48 00000000 0 5a5a0c48 0
0 00001050 00000000 0 5a5a1050 0
0 0000047c 00000000 0 5a5a047c 0
0 00000040 00000000 0 5a5a0040 0
1 00001488 deadbeef 5 deadbeef 1
0 00001488 00000000 0 5aad14ef 0
